//--- rtl/rv_pkg.sv
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int CLS_W      = 3;
    localparam int ST_W       = 2;

    localparam logic [XLEN-1:0] PC_RESET = 32'h2000_0000;
    localparam logic [XLEN-1:0] PC_STEP  = 32'd4;

    // Major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    localparam logic [2:0] F3_JALR = 3'b000;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_ADDI  = 3'b000;
    localparam logic [2:0] F3_SLTI  = 3'b010;
    localparam logic [2:0] F3_SLTIU = 3'b011;
    localparam logic [2:0] F3_XORI  = 3'b100;
    localparam logic [2:0] F3_ORI   = 3'b110;
    localparam logic [2:0] F3_ANDI  = 3'b111;
    localparam logic [2:0] F3_SLL   = 3'b001;
    localparam logic [2:0] F3_SR    = 3'b101; // SRLI and SRAI, split by funct7

    localparam logic [6:0] F7_SRA = 7'b0100000;

    // Decoded instruction classes
    localparam logic [CLS_W-1:0] CLS_LUI    = 3'd0;
    localparam logic [CLS_W-1:0] CLS_AUIPC  = 3'd1;
    localparam logic [CLS_W-1:0] CLS_JAL    = 3'd2;
    localparam logic [CLS_W-1:0] CLS_JALR   = 3'd3;
    localparam logic [CLS_W-1:0] CLS_BRANCH = 3'd4;
    localparam logic [CLS_W-1:0] CLS_OPIMM  = 3'd5;
    localparam logic [CLS_W-1:0] CLS_NOP    = 3'd6;

    // Sequencer states
    localparam logic [ST_W-1:0] ST_FETCH  = 2'd0;
    localparam logic [ST_W-1:0] ST_WAIT   = 2'd1;
    localparam logic [ST_W-1:0] ST_RETIRE = 2'd2;

    // One instruction word, seen through each encoding format
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic [6:0]  funct7;    // imm[11:5]
            logic [4:0]  rs2;       // imm[4:0], shamt
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic        imm_12;
            logic [5:0]  imm_10_5;
            logic [4:0]  rs2;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [3:0]  imm_4_1;
            logic        imm_11;
            logic [6:0]  opcode;
        } b;
        struct packed {
            logic        imm_20;
            logic [9:0]  imm_10_1;
            logic        imm_11;
            logic [7:0]  imm_19_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } j;
    } instr_t;

endpackage

//--- rtl/rv_stage_ctrl.sv
`timescale 1ns/1ps

module rv_stage_ctrl (
    input  logic                     i_clk,
    input  logic                     i_rst,
    input  logic                     i_fetch_done,
    input  logic                     i_rd_we,
    input  logic [rv_pkg::XLEN-1:0]  i_next_pc,
    output logic                     o_fetch_req,
    output logic [rv_pkg::XLEN-1:0]  o_fetch_addr,
    output logic [rv_pkg::XLEN-1:0]  o_pc,
    output logic                     o_rf_we
);

    logic [rv_pkg::ST_W-1:0]  state;
    logic [rv_pkg::XLEN-1:0]  pc;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= rv_pkg::ST_FETCH;
            pc    <= rv_pkg::PC_RESET;
        end else begin
            case (state)
                rv_pkg::ST_FETCH: begin
                    state <= rv_pkg::ST_WAIT; // Request goes out for one cycle only
                end
                rv_pkg::ST_WAIT: begin
                    if (i_fetch_done) begin
                        state <= rv_pkg::ST_RETIRE;
                    end
                end
                rv_pkg::ST_RETIRE: begin
                    pc    <= i_next_pc;
                    state <= rv_pkg::ST_FETCH;
                end
                default: begin
                    state <= rv_pkg::ST_FETCH;
                end
            endcase
        end
    end

    // Decode and execute settle while waiting; results commit here
    assign o_fetch_req  = (state == rv_pkg::ST_FETCH);
    assign o_fetch_addr = pc;
    assign o_pc         = pc;
    assign o_rf_we      = (state == rv_pkg::ST_RETIRE) && i_rd_we;

endmodule

//--- rtl/rv_wb_fetch.sv
`timescale 1ns/1ps

module rv_wb_fetch (
    input  logic                     i_clk,
    input  logic                     i_rst,
    input  logic                     i_fetch_req,
    input  logic [rv_pkg::XLEN-1:0]  i_fetch_addr,
    input  logic                     i_ack,
    input  logic                     i_stall,
    input  logic [rv_pkg::XLEN-1:0]  i_data,
    output logic                     o_cyc,
    output logic                     o_stb,
    output logic [rv_pkg::XLEN-1:0]  o_addr,
    output logic                     o_fetch_done,
    output rv_pkg::instr_t           o_instr
);

    logic ack_ok;

    assign ack_ok = o_cyc && i_ack && !i_stall; // Stalled ack does not count

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_cyc        <= 1'b0;
            o_stb        <= 1'b0;
            o_addr       <= '0;
            o_fetch_done <= 1'b0;
        end else begin
            o_fetch_done <= ack_ok;
            if (i_fetch_req) begin
                o_cyc  <= 1'b1;
                o_stb  <= 1'b1;
                o_addr <= i_fetch_addr;
            end else begin
                if (o_stb && !i_stall) begin
                    o_stb <= 1'b0; // Accepted
                end
                if (ack_ok) begin
                    o_cyc  <= 1'b0;
                    o_addr <= '0;
                end
            end
        end
    end

    // Instruction word held until the next fetch completes
    always_ff @(posedge i_clk) begin
        if (ack_ok) begin
            o_instr <= i_data;
        end
    end

endmodule

//--- rtl/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder (
    input  rv_pkg::instr_t                  i_instr,
    output logic [rv_pkg::REG_ADDR_W-1:0]   o_rs1,
    output logic [rv_pkg::REG_ADDR_W-1:0]   o_rs2,
    output logic [rv_pkg::REG_ADDR_W-1:0]   o_rd,
    output logic [rv_pkg::CLS_W-1:0]        o_cls,
    output logic [2:0]                      o_funct3,
    output logic [4:0]                      o_shamt,
    output logic                            o_sra,
    output logic [rv_pkg::XLEN-1:0]         o_imm,
    output logic                            o_rd_we
);

    logic writes_rd;

    // Register fields sit at the same bits in every format
    assign o_rs1    = i_instr.i.rs1;
    assign o_rs2    = i_instr.b.rs2;
    assign o_rd     = i_instr.u.rd;
    assign o_funct3 = i_instr.i.funct3;
    assign o_shamt  = i_instr.i.rs2;
    assign o_sra    = (i_instr.i.funct7 == rv_pkg::F7_SRA);

    always_comb begin
        o_cls = rv_pkg::CLS_NOP;
        o_imm = '0;
        case (i_instr.u.opcode)
            rv_pkg::OPC_LUI: begin
                o_cls = rv_pkg::CLS_LUI;
                o_imm = {i_instr.u.imm_31_12, 12'b0};
            end
            rv_pkg::OPC_AUIPC: begin
                o_cls = rv_pkg::CLS_AUIPC;
                o_imm = {i_instr.u.imm_31_12, 12'b0};
            end
            rv_pkg::OPC_JAL: begin
                o_cls = rv_pkg::CLS_JAL;
                o_imm = {{11{i_instr.j.imm_20}}, i_instr.j.imm_20, i_instr.j.imm_19_12,
                         i_instr.j.imm_11, i_instr.j.imm_10_1, 1'b0};
            end
            rv_pkg::OPC_JALR: begin
                if (i_instr.i.funct3 == rv_pkg::F3_JALR) begin
                    o_cls = rv_pkg::CLS_JALR;
                end
                o_imm = {{20{i_instr.i.funct7[6]}}, i_instr.i.funct7, i_instr.i.rs2};
            end
            rv_pkg::OPC_BRANCH: begin
                o_cls = rv_pkg::CLS_BRANCH;
                o_imm = {{19{i_instr.b.imm_12}}, i_instr.b.imm_12, i_instr.b.imm_11,
                         i_instr.b.imm_10_5, i_instr.b.imm_4_1, 1'b0};
            end
            rv_pkg::OPC_OP_IMM: begin
                o_cls = rv_pkg::CLS_OPIMM;
                o_imm = {{20{i_instr.i.funct7[6]}}, i_instr.i.funct7, i_instr.i.rs2};
            end
            default: begin
                o_cls = rv_pkg::CLS_NOP; // Retires as PC + 4
            end
        endcase
    end

    always_comb begin
        case (o_cls)
            rv_pkg::CLS_LUI,
            rv_pkg::CLS_AUIPC,
            rv_pkg::CLS_JAL,
            rv_pkg::CLS_JALR,
            rv_pkg::CLS_OPIMM: writes_rd = 1'b1;
            default:           writes_rd = 1'b0;
        endcase
    end

    assign o_rd_we = writes_rd && (o_rd != '0);

endmodule

//--- rtl/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
    input  logic                            i_clk,
    input  logic                            i_rst,
    input  logic [rv_pkg::REG_ADDR_W-1:0]   i_rs1,
    input  logic [rv_pkg::REG_ADDR_W-1:0]   i_rs2,
    input  logic [rv_pkg::REG_ADDR_W-1:0]   i_rd,
    input  logic                            i_we,
    input  logic [rv_pkg::XLEN-1:0]         i_wdata,
    output logic [rv_pkg::XLEN-1:0]         o_rs1_data,
    output logic [rv_pkg::XLEN-1:0]         o_rs2_data
);

    logic [rv_pkg::XLEN-1:0] regs [1:31]; // No storage for x0

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int k = 1; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (i_we && (i_rd != '0)) begin
            regs[i_rd] <= i_wdata;
        end
    end

    assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

//--- rtl/rv_execute.sv
`timescale 1ns/1ps

module rv_execute (
    input  logic [rv_pkg::XLEN-1:0]   i_pc,
    input  logic [rv_pkg::CLS_W-1:0]  i_cls,
    input  logic [2:0]                i_funct3,
    input  logic [4:0]                i_shamt,
    input  logic                      i_sra,
    input  logic [rv_pkg::XLEN-1:0]   i_imm,
    input  logic [rv_pkg::XLEN-1:0]   i_rs1_data,
    input  logic [rv_pkg::XLEN-1:0]   i_rs2_data,
    output logic [rv_pkg::XLEN-1:0]   o_rd_data,
    output logic [rv_pkg::XLEN-1:0]   o_next_pc
);

    logic [rv_pkg::XLEN-1:0] pc_plus4;
    logic [rv_pkg::XLEN-1:0] pc_rel;
    logic [rv_pkg::XLEN-1:0] reg_rel;
    logic [rv_pkg::XLEN-1:0] opimm_res;
    logic                    imm_lt_s;
    logic                    imm_lt_u;
    logic                    br_eq;
    logic                    br_lt_s;
    logic                    br_lt_u;
    logic                    br_taken;

    assign pc_plus4 = i_pc + rv_pkg::PC_STEP;
    assign pc_rel   = i_pc + i_imm;
    assign reg_rel  = (i_rs1_data + i_imm) & ~32'd1; // JALR clears bit 0

    assign imm_lt_s = $signed(i_rs1_data) < $signed(i_imm);
    assign imm_lt_u = i_rs1_data < i_imm;
    assign br_eq    = i_rs1_data == i_rs2_data;
    assign br_lt_s  = $signed(i_rs1_data) < $signed(i_rs2_data);
    assign br_lt_u  = i_rs1_data < i_rs2_data;

    always_comb begin
        case (i_funct3)
            rv_pkg::F3_ADDI:  opimm_res = i_rs1_data + i_imm;
            rv_pkg::F3_SLTI:  opimm_res = {{(rv_pkg::XLEN-1){1'b0}}, imm_lt_s};
            rv_pkg::F3_SLTIU: opimm_res = {{(rv_pkg::XLEN-1){1'b0}}, imm_lt_u};
            rv_pkg::F3_XORI:  opimm_res = i_rs1_data ^ i_imm;
            rv_pkg::F3_ORI:   opimm_res = i_rs1_data | i_imm;
            rv_pkg::F3_ANDI:  opimm_res = i_rs1_data & i_imm;
            rv_pkg::F3_SLL:   opimm_res = i_rs1_data << i_shamt;
            default: begin
                if (i_sra) begin
                    opimm_res = $signed(i_rs1_data) >>> i_shamt;
                end else begin
                    opimm_res = i_rs1_data >> i_shamt;
                end
            end
        endcase
    end

    always_comb begin
        case (i_funct3)
            rv_pkg::F3_BEQ:  br_taken = br_eq;
            rv_pkg::F3_BNE:  br_taken = !br_eq;
            rv_pkg::F3_BLT:  br_taken = br_lt_s;
            rv_pkg::F3_BGE:  br_taken = !br_lt_s;
            rv_pkg::F3_BLTU: br_taken = br_lt_u;
            rv_pkg::F3_BGEU: br_taken = !br_lt_u;
            default:         br_taken = 1'b0; // Reserved encodings fall through
        endcase
    end

    always_comb begin
        case (i_cls)
            rv_pkg::CLS_LUI:   o_rd_data = i_imm;
            rv_pkg::CLS_AUIPC: o_rd_data = pc_rel;
            rv_pkg::CLS_JAL,
            rv_pkg::CLS_JALR:  o_rd_data = pc_plus4; // Link value
            rv_pkg::CLS_OPIMM: o_rd_data = opimm_res;
            default:           o_rd_data = '0;
        endcase
    end

    always_comb begin
        case (i_cls)
            rv_pkg::CLS_JAL:    o_next_pc = pc_rel;
            rv_pkg::CLS_JALR:   o_next_pc = reg_rel;
            rv_pkg::CLS_BRANCH: o_next_pc = br_taken ? pc_rel : pc_plus4;
            default:            o_next_pc = pc_plus4;
        endcase
    end

endmodule

//--- rtl/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top (
    input  logic                     i_clk,
    input  logic                     i_rst,
    input  logic                     i_ack,
    input  logic                     i_stall,
    input  logic [rv_pkg::XLEN-1:0]  i_data,
    output logic                     o_cyc,
    output logic                     o_stb,
    output logic [rv_pkg::XLEN-1:0]  o_addr
);

    logic                           fetch_req;
    logic [rv_pkg::XLEN-1:0]        fetch_addr;
    logic                           fetch_done;
    rv_pkg::instr_t                 instr;
    logic [rv_pkg::XLEN-1:0]        pc;
    logic [rv_pkg::XLEN-1:0]        next_pc;
    logic                           rf_we;
    logic                           rd_we;
    logic [rv_pkg::REG_ADDR_W-1:0]  rs1;
    logic [rv_pkg::REG_ADDR_W-1:0]  rs2;
    logic [rv_pkg::REG_ADDR_W-1:0]  rd;
    logic [rv_pkg::CLS_W-1:0]       cls;
    logic [2:0]                     funct3;
    logic [4:0]                     shamt;
    logic                           sra;
    logic [rv_pkg::XLEN-1:0]        imm;
    logic [rv_pkg::XLEN-1:0]        rs1_data;
    logic [rv_pkg::XLEN-1:0]        rs2_data;
    logic [rv_pkg::XLEN-1:0]        rd_data;

    rv_stage_ctrl u_ctrl (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_fetch_done (fetch_done),
        .i_rd_we      (rd_we),
        .i_next_pc    (next_pc),
        .o_fetch_req  (fetch_req),
        .o_fetch_addr (fetch_addr),
        .o_pc         (pc),
        .o_rf_we      (rf_we)
    );

    rv_wb_fetch u_fetch (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_fetch_req  (fetch_req),
        .i_fetch_addr (fetch_addr),
        .i_ack        (i_ack),
        .i_stall      (i_stall),
        .i_data       (i_data),
        .o_cyc        (o_cyc),
        .o_stb        (o_stb),
        .o_addr       (o_addr),
        .o_fetch_done (fetch_done),
        .o_instr      (instr)
    );

    rv_decoder u_dec (
        .i_instr  (instr),
        .o_rs1    (rs1),
        .o_rs2    (rs2),
        .o_rd     (rd),
        .o_cls    (cls),
        .o_funct3 (funct3),
        .o_shamt  (shamt),
        .o_sra    (sra),
        .o_imm    (imm),
        .o_rd_we  (rd_we)
    );

    rv_regfile u_rf (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_rs1      (rs1),
        .i_rs2      (rs2),
        .i_rd       (rd),
        .i_we       (rf_we),
        .i_wdata    (rd_data),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    rv_execute u_exe (
        .i_pc       (pc),
        .i_cls      (cls),
        .i_funct3   (funct3),
        .i_shamt    (shamt),
        .i_sra      (sra),
        .i_imm      (imm),
        .i_rs1_data (rs1_data),
        .i_rs2_data (rs2_data),
        .o_rd_data  (rd_data),
        .o_next_pc  (next_pc)
    );

endmodule

//--- verif/tb_rv_model.svh
logic [31:0] lfsr_state = 32'h0a482d21;
logic [31:0] mregs [0:31];
logic [31:0] mpc;
logic [31:0] dir_q [$];

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0]; // Taps 32, 22, 2, 1
    return {s[30:0], fb};
endfunction

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
        lfsr_state = lfsr_next(lfsr_state);
        v = {v[30:0], lfsr_state[0]};
    end
    return v;
endfunction

function automatic void model_reset();
    for (int k = 0; k < 32; k++) begin
        mregs[k] = '0;
    end
    mpc = rv_pkg::PC_RESET;
endfunction

// Applies one instruction to the model and returns the next fetch address
function automatic logic [31:0] rv_ref_step(input logic [31:0] w);
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_u;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] res;
    logic [31:0] nxt;
    logic        wr;
    logic        tk;
    rd    = w[11:7];
    f3    = w[14:12];
    a     = mregs[w[19:15]];
    b     = mregs[w[24:20]];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_u = {w[31:12], 12'b0};
    imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    nxt   = mpc + 32'd4;
    res   = '0;
    wr    = 1'b0;
    tk    = 1'b0;
    case (w[6:0])
        rv_pkg::OPC_LUI: begin
            res = imm_u;
            wr  = 1'b1;
        end
        rv_pkg::OPC_AUIPC: begin
            res = mpc + imm_u;
            wr  = 1'b1;
        end
        rv_pkg::OPC_JAL: begin
            res = mpc + 32'd4;
            nxt = mpc + imm_j;
            wr  = 1'b1;
        end
        rv_pkg::OPC_JALR: begin
            if (f3 == 3'b000) begin
                res = mpc + 32'd4;
                nxt = (a + imm_i) & 32'hffff_fffe;
                wr  = 1'b1;
            end
        end
        rv_pkg::OPC_BRANCH: begin
            case (f3)
                3'b000: tk = (a == b);
                3'b001: tk = (a != b);
                3'b100: tk = ($signed(a) < $signed(b));
                3'b101: tk = ($signed(a) >= $signed(b));
                3'b110: tk = (a < b);
                3'b111: tk = (a >= b);
                default: tk = 1'b0;
            endcase
            if (tk) begin
                nxt = mpc + imm_b;
            end
        end
        rv_pkg::OPC_OP_IMM: begin
            wr = 1'b1;
            case (f3)
                3'b000: res = a + imm_i;
                3'b010: res = {31'b0, $signed(a) < $signed(imm_i)};
                3'b011: res = {31'b0, a < imm_i};
                3'b100: res = a ^ imm_i;
                3'b110: res = a | imm_i;
                3'b111: res = a & imm_i;
                3'b001: res = a << w[24:20];
                default: begin
                    if (w[31:25] == 7'b0100000) begin
                        res = $signed(a) >>> w[24:20];
                    end else begin
                        res = a >> w[24:20];
                    end
                end
            endcase
        end
        default: wr = 1'b0; // Anything else is a no-op
    endcase
    if (wr && rd != 5'd0) begin
        mregs[rd] = res;
    end
    mpc = nxt;
    return nxt;
endfunction

//--- verif/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

    localparam int N_INSTR = 500;
    localparam int TIMEOUT = 10 + N_INSTR * 12;

    logic                     i_clk;
    logic                     i_rst;
    logic                     i_ack;
    logic                     i_stall;
    logic [rv_pkg::XLEN-1:0]  i_data;
    logic                     o_cyc;
    logic                     o_stb;
    logic [rv_pkg::XLEN-1:0]  o_addr;
    int                       cycles;

    `include "tb_rv_model.svh"

    rv_core_top UUT (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_ack   (i_ack),
        .i_stall (i_stall),
        .i_data  (i_data),
        .o_cyc   (o_cyc),
        .o_stb   (o_stb),
        .o_addr  (o_addr)
    );

    always #20 i_clk = ~i_clk;

    function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [4:0] rd,
                                          input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        rv_pkg::instr_t w;
        w.i.opcode = opc;
        w.i.rd     = rd;
        w.i.funct3 = f3;
        w.i.rs1    = rs1;
        w.i.funct7 = imm[11:5];
        w.i.rs2    = imm[4:0];
        return w.raw;
    endfunction

    function automatic logic [31:0] enc_u(input logic [6:0] opc, input logic [4:0] rd,
                                          input logic [19:0] imm);
        rv_pkg::instr_t w;
        w.u.opcode    = opc;
        w.u.rd        = rd;
        w.u.imm_31_12 = imm;
        return w.raw;
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] off);
        rv_pkg::instr_t w;
        w.b.opcode   = rv_pkg::OPC_BRANCH;
        w.b.funct3   = f3;
        w.b.rs1      = rs1;
        w.b.rs2      = rs2;
        w.b.imm_12   = off[12];
        w.b.imm_11   = off[11];
        w.b.imm_10_5 = off[10:5];
        w.b.imm_4_1  = off[4:1];
        return w.raw;
    endfunction

    function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] off);
        rv_pkg::instr_t w;
        w.j.opcode    = rv_pkg::OPC_JAL;
        w.j.rd        = rd;
        w.j.imm_20    = off[20];
        w.j.imm_19_12 = off[19:12];
        w.j.imm_11    = off[11];
        w.j.imm_10_1  = off[10:1];
        return w.raw;
    endfunction

    // JALR through rd so that the fetch address reveals its value
    function automatic void push_reveal(input logic [31:0] op, input logic [4:0] rd,
                                        input logic [11:0] off);
        dir_q.push_back(op);
        dir_q.push_back(enc_i(rv_pkg::OPC_JALR, 5'd0, rv_pkg::F3_JALR, rd, off));
    endfunction

    function automatic void build_directed();
        push_reveal(enc_u(rv_pkg::OPC_LUI, 5'd1, 20'h12345), 5'd1, 12'h010);
        push_reveal(enc_u(rv_pkg::OPC_AUIPC, 5'd2, 20'hfffff), 5'd2, 12'hffd);
        push_reveal(enc_i(rv_pkg::OPC_OP_IMM, 5'd3, rv_pkg::F3_ADDI, 5'd0, 12'hffb), 5'd3, 12'h0);
        // Compare results moved up past bit 0
        dir_q.push_back(enc_i(rv_pkg::OPC_OP_IMM, 5'd4, rv_pkg::F3_SLTI, 5'd3, 12'h001));
        push_reveal(enc_i(rv_pkg::OPC_OP_IMM, 5'd4, rv_pkg::F3_SLL, 5'd4, 12'h002), 5'd4, 12'h20);
        dir_q.push_back(enc_i(rv_pkg::OPC_OP_IMM, 5'd5, rv_pkg::F3_SLTIU, 5'd3, 12'h001));
        push_reveal(enc_i(rv_pkg::OPC_OP_IMM, 5'd5, rv_pkg::F3_SLL, 5'd5, 12'h002), 5'd5, 12'h40);
        push_reveal(enc_i(rv_pkg::OPC_OP_IMM, 5'd6, rv_pkg::F3_XORI, 5'd3, 12'hfff), 5'd6, 12'h0);
        push_reveal(enc_i(rv_pkg::OPC_OP_IMM, 5'd7, rv_pkg::F3_ORI, 5'd1, 12'h123), 5'd7, 12'h0);
        push_reveal(enc_i(rv_pkg::OPC_OP_IMM, 5'd8, rv_pkg::F3_ANDI, 5'd1, 12'hf0f), 5'd8, 12'h0);
        push_reveal(enc_i(rv_pkg::OPC_OP_IMM, 5'd9, rv_pkg::F3_SLL, 5'd3, 12'h004), 5'd9, 12'h0);
        push_reveal(enc_i(rv_pkg::OPC_OP_IMM, 5'd10, rv_pkg::F3_SR, 5'd3, 12'h004), 5'd10, 12'h0);
        push_reveal(enc_i(rv_pkg::OPC_OP_IMM, 5'd11, rv_pkg::F3_SR, 5'd3, 12'h404), 5'd11, 12'h0);
        push_reveal(enc_i(rv_pkg::OPC_OP_IMM, 5'd0, rv_pkg::F3_ADDI, 5'd3, 12'h055), 5'd0, 12'h100);
        dir_q.push_back(enc_i(rv_pkg::OPC_OP_IMM, 5'd12, rv_pkg::F3_ADDI, 5'd0, 12'h007));
        for (int k = 0; k < 2; k++) begin // Taken, then not taken
            dir_q.push_back(enc_b(rv_pkg::F3_BEQ, 5'd3, (k == 0) ? 5'd3 : 5'd12, 13'd16));
            dir_q.push_back(enc_b(rv_pkg::F3_BNE, 5'd3, (k == 0) ? 5'd12 : 5'd3, 13'h1ff8));
            dir_q.push_back(enc_b(rv_pkg::F3_BLT, (k == 0) ? 5'd3 : 5'd12, 5'd12, 13'd32));
            dir_q.push_back(enc_b(rv_pkg::F3_BGE, (k == 0) ? 5'd12 : 5'd3, 5'd12, 13'd24));
            dir_q.push_back(enc_b(rv_pkg::F3_BLTU, (k == 0) ? 5'd12 : 5'd3, 5'd3, 13'd40));
            dir_q.push_back(enc_b(rv_pkg::F3_BGEU, (k == 0) ? 5'd3 : 5'd12, 5'd3, 13'd8));
        end
        dir_q.push_back(enc_j(5'd1, 21'd64));
        dir_q.push_back(enc_i(rv_pkg::OPC_JALR, 5'd0, rv_pkg::F3_JALR, 5'd1, 12'h0));
        dir_q.push_back(32'h0000_007f); // Unknown opcode
        dir_q.push_back(32'h00b5_0533); // Register-register op, not kept
        dir_q.push_back(enc_i(rv_pkg::OPC_JALR, 5'd1, 3'b001, 5'd3, 12'h0));
    endfunction

    function automatic logic [31:0] next_instr();
        logic [31:0] r;
        logic [31:0] imm;
        logic [2:0]  f3;
        logic [2:0]  kind;
        if (dir_q.size() > 0) begin
            return dir_q.pop_front();
        end
        r    = rand_bits(15);
        imm  = rand_bits(20);
        f3   = 3'(rand_bits(3));
        kind = 3'(rand_bits(3));
        case (kind)
            3'd0: return enc_u(rv_pkg::OPC_LUI, r[4:0], imm[19:0]);
            3'd1: return enc_u(rv_pkg::OPC_AUIPC, r[4:0], imm[19:0]);
            3'd2: return enc_j(r[4:0], {imm[19:0], 1'b0});
            3'd3: return enc_i(rv_pkg::OPC_JALR, r[4:0], rv_pkg::F3_JALR, r[9:5], imm[11:0]);
            3'd4: begin
                if (f3[2:1] == 2'b01) begin
                    f3 = rv_pkg::F3_BEQ;
                end
                return enc_b(f3, r[9:5], r[14:10], {imm[11:0], 1'b0});
            end
            3'd7: return {imm[19:0], r[4:0], imm[0] ? 7'b1111111 : 7'b0110011};
            default: begin
                if (f3 == rv_pkg::F3_SLL || f3 == rv_pkg::F3_SR) begin
                    imm[11:5] = (f3 == rv_pkg::F3_SR && imm[0]) ? rv_pkg::F7_SRA : 7'b0;
                end
                return enc_i(rv_pkg::OPC_OP_IMM, r[4:0], f3, r[9:5], imm[11:0]);
            end
        endcase
    endfunction

    task automatic check_word(input string name, input logic [rv_pkg::XLEN-1:0] got,
                              input logic [rv_pkg::XLEN-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
            $display("Some tests failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
            $display("Some tests failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("Timeout after %0d cycles, the core stopped fetching", cycles);
            $display("Some tests failed");
            $fatal(1, "stopping on timeout");
        end
    end

    initial begin
        logic [31:0] exp_pc;
        logic [31:0] word;
        int          stall_left;
        int          ack_wait;
        int          gap;
        i_clk   = 1'b0;
        i_rst   = 1'b1;
        i_ack   = 1'b0;
        i_stall = 1'b0;
        i_data  = '0;
        cycles  = 0;
        model_reset();
        build_directed();
        exp_pc  = rv_pkg::PC_RESET;
        for (int k = 0; k < 10; k++) begin
            @(posedge i_clk);
            if (k > 0) begin
                check_bit("o_cyc", o_cyc, 1'b0);
                check_bit("o_stb", o_stb, 1'b0);
                check_word("o_addr", o_addr, '0);
            end
        end
        i_rst <= 1'b0;
        stall_left = 0;
        for (int n = 0; n < N_INSTR; n++) begin
            gap = 0;
            do begin
                @(posedge i_clk);
                gap++;
                if (!o_stb) begin
                    check_bit("o_cyc", o_cyc, 1'b0);
                    check_word("o_addr", o_addr, '0);
                end
            end while (!o_stb);
            if (n > 0) begin
                check_word("o_stb rise gap", gap, 32'd4); // Ack edge to first strobe edge
            end
            while (stall_left > 0) begin
                check_bit("o_stb", o_stb, 1'b1);
                check_word("o_addr", o_addr, exp_pc);
                stall_left--;
                if (stall_left == 0) begin
                    i_stall <= 1'b0;
                end
                @(posedge i_clk);
            end
            check_bit("o_stb", o_stb, 1'b1);
            check_word("o_addr", o_addr, exp_pc);
            word     = next_instr();
            ack_wait = int'(rand_bits(2));
            i_data  <= word;
            for (int d = 0; d < ack_wait; d++) begin
                @(posedge i_clk);
                check_bit("o_stb", o_stb, 1'b0);
                check_bit("o_cyc", o_cyc, 1'b1);
            end
            i_ack <= 1'b1;
            @(posedge i_clk);
            check_bit("o_cyc", o_cyc, 1'b1);
            check_bit("o_stb", o_stb, 1'b0);
            i_ack     <= 1'b0;
            exp_pc     = rv_ref_step(word);
            stall_left = int'(rand_bits(2));
            i_stall   <= (stall_left > 0);
        end
        $display("All tests passed");
        $finish;
    end

endmodule

//--- list.f
+incdir+verif
rtl/rv_pkg.sv
rtl/rv_stage_ctrl.sv
rtl/rv_wb_fetch.sv
rtl/rv_decoder.sv
rtl/rv_regfile.sv
rtl/rv_execute.sv
rtl/rv_core_top.sv
verif/tb_rv_core.sv

//--- run.sh
#!/usr/bin/env bash
# Builds and runs the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_rv_core -f list.f -o sim_tb || exit 1

out=$(./obj_dir/sim_tb 2>&1)
echo "$out"

echo "$out" | grep -q "All tests passed" && exit 0 || exit 1
